/* design/mem_pkg.sv */
`default_nettype none

package mem_pkg;

  typedef logic [31:0] addr_t;    // byte address
  typedef logic [31:0] word_t;
  typedef logic [3:0]  strb_t;    // one bit per byte lane
  typedef logic [3:0]  axi_id_t;

  // load/store operations as issued by the core
  typedef enum logic [2:0] {
    LB,
    LH,
    LW,
    LBU,
    LHU,
    SB,
    SH,
    SW
  } mem_op_e;

  // word-aligned request between aligner, arbiter and AXI master
  typedef struct packed {
    addr_t addr;
    logic  write;
    word_t wdata;
    strb_t wstrb;
  } mem_req_t;

  typedef struct packed {
    word_t rdata;
    logic  err;
  } mem_rsp_t;

  // AXI4 channel payloads, sideband signals left out
  typedef struct packed {
    addr_t      addr;
    axi_id_t    id;
    logic [7:0] len;
    logic [2:0] size;
    logic [1:0] burst;
  } axi_ar_t;

  typedef struct packed {
    addr_t      addr;
    axi_id_t    id;
    logic [7:0] len;
    logic [2:0] size;
    logic [1:0] burst;
  } axi_aw_t;

  typedef struct packed {
    word_t data;
    strb_t strb;
    logic  last;
  } axi_w_t;

  typedef struct packed {
    word_t      data;
    logic [1:0] resp;
    logic       last;
    axi_id_t    id;
  } axi_r_t;

  typedef struct packed {
    logic [1:0] resp;
    axi_id_t    id;
  } axi_b_t;

  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

/* design/lsu_align.sv */
`timescale 1ns/1ns
`default_nettype none

module lsu_align (
  input  logic              clk,
  input  logic              arst_n_i,
  input  logic              lsu_valid_i,
  input  mem_pkg::mem_op_e  lsu_op_i,
  input  mem_pkg::addr_t    lsu_addr_i,
  input  mem_pkg::word_t    lsu_wdata_i,
  output logic              lsu_done_o,
  output mem_pkg::word_t    lsu_rdata_o,
  output logic              lsu_err_o,
  output logic              req_valid_o,
  output mem_pkg::mem_req_t req_o,
  input  logic              rsp_done_i,
  input  mem_pkg::mem_rsp_t rsp_i
);

  logic           misaligned;
  logic           is_store;
  logic           mis_done_q;  // misaligned access answered locally
  mem_pkg::strb_t wstrb;
  mem_pkg::word_t lane_word;
  mem_pkg::word_t load_data;

  // halves need bit 0 clear, words need both low bits clear
  always_comb begin
    case (lsu_op_i)
      mem_pkg::LH, mem_pkg::LHU, mem_pkg::SH: misaligned = lsu_addr_i[0];
      mem_pkg::LW, mem_pkg::SW:               misaligned = |lsu_addr_i[1:0];
      default:                                misaligned = 1'b0;
    endcase
  end

  assign is_store = lsu_op_i inside {mem_pkg::SB, mem_pkg::SH, mem_pkg::SW};

  always_comb begin
    case (lsu_op_i)
      mem_pkg::SB: wstrb = 4'b0001 << lsu_addr_i[1:0];
      mem_pkg::SH: wstrb = 4'b0011 << {lsu_addr_i[1], 1'b0};
      mem_pkg::SW: wstrb = 4'b1111;
      default:     wstrb = 4'b0000;  // loads
    endcase
  end

  assign req_valid_o = lsu_valid_i & ~misaligned;
  assign req_o.addr  = {lsu_addr_i[31:2], 2'b00};
  assign req_o.write = is_store;
  assign req_o.wdata = lsu_wdata_i << {lsu_addr_i[1:0], 3'b000};  // into byte lane
  assign req_o.wstrb = wstrb;

  // addressed byte or half moved down to bit 0
  assign lane_word = rsp_i.rdata >> {lsu_addr_i[1:0], 3'b000};

  always_comb begin
    case (lsu_op_i)
      mem_pkg::LB:  load_data = {{24{lane_word[7]}}, lane_word[7:0]};
      mem_pkg::LBU: load_data = {24'b0, lane_word[7:0]};
      mem_pkg::LH:  load_data = {{16{lane_word[15]}}, lane_word[15:0]};
      mem_pkg::LHU: load_data = {16'b0, lane_word[15:0]};
      mem_pkg::LW:  load_data = rsp_i.rdata;
      default:      load_data = '0;  // stores return nothing
    endcase
  end

  // one-cycle reply, blocked while the held request is being answered
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mis_done_q <= 1'b0;
    end else begin
      mis_done_q <= lsu_valid_i & misaligned & ~mis_done_q;
    end
  end

  assign lsu_done_o  = mis_done_q | rsp_done_i;
  assign lsu_err_o   = mis_done_q | (rsp_done_i & rsp_i.err);
  assign lsu_rdata_o = mis_done_q ? '0 : load_data;

endmodule

`default_nettype wire

/* design/bus_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module bus_arbiter (
  input  logic              clk,
  input  logic              arst_n_i,
  input  logic              fetch_valid_i,
  input  mem_pkg::addr_t    fetch_addr_i,
  output logic              fetch_done_o,
  output mem_pkg::mem_rsp_t fetch_rsp_o,
  input  logic              data_valid_i,
  input  mem_pkg::mem_req_t data_req_i,
  output logic              data_done_o,
  output mem_pkg::mem_rsp_t data_rsp_o,
  output logic              bus_valid_o,
  output mem_pkg::mem_req_t bus_req_o,
  output logic              bus_is_data_o,
  input  logic              bus_done_i,
  input  mem_pkg::mem_rsp_t bus_rsp_i
);

  typedef enum logic [1:0] {
    OWN_NONE,
    OWN_FETCH,
    OWN_DATA
  } owner_e;

  owner_e            owner_q;
  logic              grant_data;
  logic              grant_fetch;
  logic              sel_data;
  mem_pkg::mem_req_t fetch_req;

  // fetch is always a full-word read
  assign fetch_req.addr  = {fetch_addr_i[31:2], 2'b00};
  assign fetch_req.write = 1'b0;
  assign fetch_req.wdata = '0;
  assign fetch_req.wstrb = '1;

  // data port wins when both ask in the same idle cycle
  assign grant_data  = (owner_q == OWN_NONE) & data_valid_i;
  assign grant_fetch = (owner_q == OWN_NONE) & ~data_valid_i & fetch_valid_i;

  assign sel_data      = grant_data | (owner_q == OWN_DATA);
  assign bus_valid_o   = grant_data | grant_fetch;  // one cycle, master latches it
  assign bus_is_data_o = sel_data;
  assign bus_req_o     = sel_data ? data_req_i : fetch_req;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      owner_q <= OWN_NONE;
    end else begin
      case (owner_q)
        OWN_NONE: begin
          if (grant_data) owner_q <= OWN_DATA;
          else if (grant_fetch) owner_q <= OWN_FETCH;
        end
        default: begin
          if (bus_done_i) owner_q <= OWN_NONE;  // free again next cycle
        end
      endcase
    end
  end

  // response only goes back to whoever holds the bus
  assign data_done_o  = bus_done_i & (owner_q == OWN_DATA);
  assign fetch_done_o = bus_done_i & (owner_q == OWN_FETCH);
  assign data_rsp_o   = (owner_q == OWN_DATA) ? bus_rsp_i : '0;
  assign fetch_rsp_o  = (owner_q == OWN_FETCH) ? bus_rsp_i : '0;

endmodule

`default_nettype wire

/* design/axi4_master.sv */
`timescale 1ns/1ns
`default_nettype none

module axi4_master #(
  parameter mem_pkg::axi_id_t FETCH_AXI_ID = 4'd0,
  parameter mem_pkg::axi_id_t DATA_AXI_ID  = 4'd1
) (
  input  logic              clk,
  input  logic              arst_n_i,
  input  logic              req_valid_i,
  input  mem_pkg::mem_req_t req_i,
  input  logic              req_is_data_i,
  output logic              done_o,
  output mem_pkg::mem_rsp_t rsp_o,
  // read address / data
  output mem_pkg::axi_ar_t  ar_o,
  output logic              ar_valid_o,
  input  logic              ar_ready_i,
  input  mem_pkg::axi_r_t   r_i,
  input  logic              r_valid_i,
  output logic              r_ready_o,
  // write address / data / response
  output mem_pkg::axi_aw_t  aw_o,
  output logic              aw_valid_o,
  input  logic              aw_ready_i,
  output mem_pkg::axi_w_t   w_o,
  output logic              w_valid_o,
  input  logic              w_ready_i,
  input  mem_pkg::axi_b_t   b_i,
  input  logic              b_valid_i,
  output logic              b_ready_o
);

  localparam logic [2:0] AXI_SIZE_4B = 3'd2;
  localparam logic [1:0] AXI_BURST_INCR = 2'b01;

  typedef enum logic [2:0] {
    IDLE,
    RD_ADDR,
    RD_DATA,
    WR_ADDR_DATA,
    WR_RESP
  } state_e;

  state_e            state_q;
  logic              aw_done_q;  // AW accepted, W may still be pending
  logic              w_done_q;
  logic              aw_fin;
  logic              w_fin;
  mem_pkg::mem_req_t req_q;      // request latched at start
  mem_pkg::axi_id_t  id_q;

  assign aw_fin = aw_done_q | (aw_valid_o & aw_ready_i);
  assign w_fin  = w_done_q | (w_valid_o & w_ready_i);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= IDLE;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (req_valid_i) state_q <= req_i.write ? WR_ADDR_DATA : RD_ADDR;
        end
        RD_ADDR: begin
          if (ar_ready_i) state_q <= RD_DATA;
        end
        RD_DATA: begin
          if (r_valid_i) state_q <= IDLE;
        end
        WR_ADDR_DATA: begin
          // AW and W may complete in either order
          if (aw_fin && w_fin) begin
            state_q   <= WR_RESP;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
          end else begin
            aw_done_q <= aw_fin;
            w_done_q  <= w_fin;
          end
        end
        WR_RESP: begin
          if (b_valid_i) state_q <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == IDLE && req_valid_i) begin
      req_q <= req_i;
      id_q  <= req_is_data_i ? DATA_AXI_ID : FETCH_AXI_ID;
    end
  end

  // single beat only
  assign ar_o.addr  = req_q.addr;
  assign ar_o.id    = id_q;
  assign ar_o.len   = 8'd0;
  assign ar_o.size  = AXI_SIZE_4B;
  assign ar_o.burst = AXI_BURST_INCR;

  assign aw_o.addr  = req_q.addr;
  assign aw_o.id    = id_q;
  assign aw_o.len   = 8'd0;
  assign aw_o.size  = AXI_SIZE_4B;
  assign aw_o.burst = AXI_BURST_INCR;

  assign w_o.data = req_q.wdata;
  assign w_o.strb = req_q.wstrb;
  assign w_o.last = 1'b1;

  assign ar_valid_o = (state_q == RD_ADDR);
  assign aw_valid_o = (state_q == WR_ADDR_DATA) & ~aw_done_q;
  assign w_valid_o  = (state_q == WR_ADDR_DATA) & ~w_done_q;
  assign r_ready_o  = (state_q == RD_DATA);
  assign b_ready_o  = (state_q == WR_RESP);

  // done in the same cycle as the R or B handshake
  assign done_o = (r_ready_o & r_valid_i) | (b_ready_o & b_valid_i);

  always_comb begin
    rsp_o = '0;
    if (state_q == RD_DATA) begin
      rsp_o.rdata = r_i.data;
      rsp_o.err   = (r_i.resp != mem_pkg::AXI_RESP_OKAY);
    end else if (state_q == WR_RESP) begin
      rsp_o.err = (b_i.resp != mem_pkg::AXI_RESP_OKAY);  // SLVERR or DECERR
    end
  end

endmodule

`default_nettype wire

/* design/mem_subsys_top.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_subsys_top #(
  parameter mem_pkg::axi_id_t FETCH_AXI_ID = 4'd0,
  parameter mem_pkg::axi_id_t DATA_AXI_ID  = 4'd1
) (
  input  logic               clk,
  input  logic               arst_n_i,
  // instruction fetch port
  input  logic               fetch_valid_i,
  input  mem_pkg::addr_t     fetch_addr_i,
  output logic               fetch_done_o,
  output mem_pkg::mem_rsp_t  fetch_rsp_o,
  // load/store port
  input  logic               lsu_valid_i,
  input  mem_pkg::mem_op_e   lsu_op_i,
  input  mem_pkg::addr_t     lsu_addr_i,
  input  mem_pkg::word_t     lsu_wdata_i,
  output logic               lsu_done_o,
  output mem_pkg::word_t     lsu_rdata_o,
  output logic               lsu_err_o,
  // AXI4 master
  output mem_pkg::axi_ar_t   ar_o,
  output logic               ar_valid_o,
  input  logic               ar_ready_i,
  input  mem_pkg::axi_r_t    r_i,
  input  logic               r_valid_i,
  output logic               r_ready_o,
  output mem_pkg::axi_aw_t   aw_o,
  output logic               aw_valid_o,
  input  logic               aw_ready_i,
  output mem_pkg::axi_w_t    w_o,
  output logic               w_valid_o,
  input  logic               w_ready_i,
  input  mem_pkg::axi_b_t    b_i,
  input  logic               b_valid_i,
  output logic               b_ready_o
);

  // aligner <-> arbiter
  mem_pkg::mem_req_t data_req;
  logic              data_req_valid;
  mem_pkg::mem_rsp_t data_rsp;
  logic              data_done;

  // arbiter <-> AXI master
  mem_pkg::mem_req_t bus_req;
  logic              bus_valid;
  logic              bus_is_data;
  mem_pkg::mem_rsp_t bus_rsp;
  logic              bus_done;

  lsu_align i_lsu_align (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .lsu_valid_i (lsu_valid_i),
    .lsu_op_i    (lsu_op_i),
    .lsu_addr_i  (lsu_addr_i),
    .lsu_wdata_i (lsu_wdata_i),
    .lsu_done_o  (lsu_done_o),
    .lsu_rdata_o (lsu_rdata_o),
    .lsu_err_o   (lsu_err_o),
    .req_valid_o (data_req_valid),
    .req_o       (data_req),
    .rsp_done_i  (data_done),
    .rsp_i       (data_rsp)
  );

  bus_arbiter i_bus_arbiter (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_addr_i  (fetch_addr_i),
    .fetch_done_o  (fetch_done_o),
    .fetch_rsp_o   (fetch_rsp_o),
    .data_valid_i  (data_req_valid),
    .data_req_i    (data_req),
    .data_done_o   (data_done),
    .data_rsp_o    (data_rsp),
    .bus_valid_o   (bus_valid),
    .bus_req_o     (bus_req),
    .bus_is_data_o (bus_is_data),
    .bus_done_i    (bus_done),
    .bus_rsp_i     (bus_rsp)
  );

  axi4_master #(
    .FETCH_AXI_ID (FETCH_AXI_ID),
    .DATA_AXI_ID  (DATA_AXI_ID)
  ) i_axi4_master (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .req_valid_i   (bus_valid),
    .req_i         (bus_req),
    .req_is_data_i (bus_is_data),
    .done_o        (bus_done),
    .rsp_o         (bus_rsp),
    .ar_o          (ar_o),
    .ar_valid_o    (ar_valid_o),
    .ar_ready_i    (ar_ready_i),
    .r_i           (r_i),
    .r_valid_i     (r_valid_i),
    .r_ready_o     (r_ready_o),
    .aw_o          (aw_o),
    .aw_valid_o    (aw_valid_o),
    .aw_ready_i    (aw_ready_i),
    .w_o           (w_o),
    .w_valid_o     (w_valid_o),
    .w_ready_i     (w_ready_i),
    .b_i           (b_i),
    .b_valid_i     (b_valid_i),
    .b_ready_o     (b_ready_o)
  );

endmodule

`default_nettype wire

/* tests/axi_mem_model.sv */
`timescale 1ns/1ns
`default_nettype none

module axi_mem_model #(
  parameter int             DEPTH    = 256,
  parameter mem_pkg::addr_t ERR_ADDR = 32'h0000_03f0,
  parameter logic [31:0]    SEED     = 32'h1
) (
  input  logic             clk,
  input  logic             arst_n_i,
  input  mem_pkg::axi_ar_t ar_i,
  input  logic             ar_valid_i,
  output logic             ar_ready_o,
  output mem_pkg::axi_r_t  r_o,
  output logic             r_valid_o,
  input  logic             r_ready_i,
  input  mem_pkg::axi_aw_t aw_i,
  input  logic             aw_valid_i,
  output logic             aw_ready_o,
  input  mem_pkg::axi_w_t  w_i,
  input  logic             w_valid_i,
  output logic             w_ready_o,
  output mem_pkg::axi_b_t  b_o,
  output logic             b_valid_o,
  input  logic             b_ready_i
);

  localparam logic [1:0] RESP_SLVERR = 2'b10;

  mem_pkg::word_t   mem [0:DEPTH-1];  // also read by tb_top for expected data
  integer           seed;
  logic [31:0]      rnd;
  logic             in_reset;
  logic             ar_hs;
  logic             r_hs;
  logic             aw_hs;
  logic             w_hs;
  logic             b_hs;
  logic             aw_got;
  logic             w_got;
  mem_pkg::axi_ar_t ar_q;
  mem_pkg::axi_aw_t aw_q;
  mem_pkg::axi_w_t  w_q;
  int               idx;

  function automatic int word_index(input mem_pkg::addr_t addr);
    return (addr >> 2) % DEPTH;
  endfunction

  initial begin
    seed = SEED;
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = 32'(i * 4) * 32'h9e37_79b1 + 32'h5bd1_e995;  // every address bit shows up
    end
    ar_ready_o = 1'b0;
    aw_ready_o = 1'b0;
    w_ready_o  = 1'b0;
    r_valid_o  = 1'b0;
    b_valid_o  = 1'b0;
    r_o        = '0;
    b_o        = '0;
    aw_got     = 1'b0;
    w_got      = 1'b0;
  end

  always begin
    @(negedge clk);
    // everything is stable here, these transfers happen at the next rising edge
    in_reset = !arst_n_i;
    ar_hs = ar_valid_i & ar_ready_o;
    r_hs  = r_valid_o & r_ready_i;
    aw_hs = aw_valid_i & aw_ready_o;
    w_hs  = w_valid_i & w_ready_o;
    b_hs  = b_valid_o & b_ready_i;
    if (ar_hs) ar_q = ar_i;
    if (aw_hs) aw_q = aw_i;
    if (w_hs) w_q = w_i;
    @(posedge clk);
    #5;
    if (in_reset) begin
      ar_ready_o = 1'b0;
      aw_ready_o = 1'b0;
      w_ready_o  = 1'b0;
      r_valid_o  = 1'b0;
      b_valid_o  = 1'b0;
      aw_got     = 1'b0;
      w_got      = 1'b0;
    end else begin
      rnd = $random(seed);
      ar_ready_o = rnd[0];  // random back-pressure
      aw_ready_o = rnd[1];
      w_ready_o  = rnd[2];
      if (r_hs) r_valid_o = 1'b0;
      if (b_hs) b_valid_o = 1'b0;
      if (ar_hs) begin
        r_o.data  = (ar_q.addr == ERR_ADDR) ? '0 : mem[word_index(ar_q.addr)];
        r_o.resp  = (ar_q.addr == ERR_ADDR) ? RESP_SLVERR : mem_pkg::AXI_RESP_OKAY;
        r_o.last  = 1'b1;
        r_o.id    = ar_q.id;
        r_valid_o = 1'b1;
      end
      aw_got = aw_got | aw_hs;
      w_got  = w_got | w_hs;
      if (aw_got && w_got) begin
        if (aw_q.addr != ERR_ADDR) begin
          idx = word_index(aw_q.addr);
          for (int b = 0; b < 4; b++) begin
            if (w_q.strb[b]) mem[idx][8*b +: 8] = w_q.data[8*b +: 8];
          end
        end
        b_o.resp  = (aw_q.addr == ERR_ADDR) ? RESP_SLVERR : mem_pkg::AXI_RESP_OKAY;
        b_o.id    = aw_q.id;
        b_valid_o = 1'b1;
        aw_got    = 1'b0;
        w_got     = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* tests/tb_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_top;

  localparam mem_pkg::axi_id_t FETCH_ID = 4'h3;
  localparam mem_pkg::axi_id_t DATA_ID  = 4'h5;
  localparam logic [31:0]      SEED     = 32'h3999ed42;
  localparam int               MEM_WORDS = 256;
  localparam mem_pkg::addr_t   ERR_ADDR = 32'h0000_03f0;
  localparam int RESET_CYCLES   = 10;
  localparam int NUM_TX         = 36;
  localparam int TX_CYCLES      = 55;  // worst case per access under back-pressure
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_TX * TX_CYCLES;

  logic               clk;
  logic               arst_n_i;
  logic               fetch_valid_i;
  mem_pkg::addr_t     fetch_addr_i;
  logic               fetch_done_o;
  mem_pkg::mem_rsp_t  fetch_rsp_o;
  logic               lsu_valid_i;
  mem_pkg::mem_op_e   lsu_op_i;
  mem_pkg::addr_t     lsu_addr_i;
  mem_pkg::word_t     lsu_wdata_i;
  logic               lsu_done_o;
  mem_pkg::word_t     lsu_rdata_o;
  logic               lsu_err_o;
  mem_pkg::axi_ar_t   ar_o;
  logic               ar_valid_o;
  logic               ar_ready_i;
  mem_pkg::axi_r_t    r_i;
  logic               r_valid_i;
  logic               r_ready_o;
  mem_pkg::axi_aw_t   aw_o;
  logic               aw_valid_o;
  logic               aw_ready_i;
  mem_pkg::axi_w_t    w_o;
  logic               w_valid_o;
  logic               w_ready_i;
  mem_pkg::axi_b_t    b_i;
  logic               b_valid_i;
  logic               b_ready_o;

  int errors = 0;
  int done_seq = 0;       // completion order of requests
  int valid_cycles = 0;   // cycles with any master valid up
  mem_pkg::axi_ar_t last_ar;
  mem_pkg::axi_aw_t last_aw;
  mem_pkg::axi_w_t  last_w;
  mem_pkg::axi_ar_t ar_prev;
  mem_pkg::axi_aw_t aw_prev;
  mem_pkg::axi_w_t  w_prev;
  logic ar_wait = 1'b0;
  logic aw_wait = 1'b0;
  logic w_wait = 1'b0;
  logic fetch_done_q = 1'b0;
  logic lsu_done_q = 1'b0;

  mem_subsys_top #(
    .FETCH_AXI_ID (FETCH_ID),
    .DATA_AXI_ID  (DATA_ID)
  ) i_dut (.*);

  axi_mem_model #(
    .DEPTH    (MEM_WORDS),
    .ERR_ADDR (ERR_ADDR),
    .SEED     (SEED)
  ) i_mem (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .ar_i       (ar_o),
    .ar_valid_i (ar_valid_o),
    .ar_ready_o (ar_ready_i),
    .r_o        (r_i),
    .r_valid_o  (r_valid_i),
    .r_ready_i  (r_ready_o),
    .aw_i       (aw_o),
    .aw_valid_i (aw_valid_o),
    .aw_ready_o (aw_ready_i),
    .w_i        (w_o),
    .w_valid_i  (w_valid_o),
    .w_ready_o  (w_ready_i),
    .b_o        (b_i),
    .b_valid_o  (b_valid_i),
    .b_ready_i  (b_ready_o)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED %s expected %h got %h", name, exp, got);
      errors++;
    end
  endtask

  task automatic require(input logic cond, input string what);
    assert (cond) else begin
      $display("%s", what);
      errors++;
    end
  endtask

  function automatic mem_pkg::word_t model_word(input mem_pkg::addr_t addr);
    return i_mem.mem[(addr >> 2) % MEM_WORDS];
  endfunction

  // lanes covered by the access counted up from the byte offset
  function automatic mem_pkg::strb_t exp_strb(input mem_pkg::mem_op_e op,
                                              input logic [1:0] off);
    int             nbytes;
    mem_pkg::strb_t s;
    nbytes = (op == mem_pkg::SB) ? 1 : (op == mem_pkg::SH) ? 2 : 4;
    for (int b = 0; b < 4; b++) s[b] = (b >= off) && (b < off + nbytes);
    return s;
  endfunction

  function automatic mem_pkg::word_t exp_load(input mem_pkg::mem_op_e op,
                                              input mem_pkg::word_t word, input logic [1:0] off);
    logic [7:0]  by;
    logic [15:0] hw;
    by = word[8*off +: 8];
    hw = word[16*off[1] +: 16];
    case (op)
      mem_pkg::LB:  return 32'($signed(by));
      mem_pkg::LBU: return 32'(by);
      mem_pkg::LH:  return 32'($signed(hw));
      mem_pkg::LHU: return 32'(hw);
      default:      return word;
    endcase
  endfunction

  task automatic verify_addr_beat(input string ch, input mem_pkg::axi_ar_t beat,
                                  input mem_pkg::axi_id_t id, input mem_pkg::addr_t addr);
    check_eq({ch, "id"}, beat.id, id);
    check_eq({ch, "len"}, beat.len, 8'd0);
    check_eq({ch, "size"}, beat.size, 3'd2);
    check_eq({ch, "burst"}, beat.burst, 2'b01);  // INCR
    check_eq({ch, "addr"}, beat.addr, {addr[31:2], 2'b00});
  endtask

  task automatic fetch(input mem_pkg::addr_t addr, output mem_pkg::mem_rsp_t rsp,
                       output int order);
    fetch_valid_i = 1'b1;
    fetch_addr_i  = addr;
    @(negedge clk);
    while (!fetch_done_o) @(negedge clk);
    rsp   = fetch_rsp_o;
    order = done_seq;
    done_seq++;
    @(posedge clk);
    #5;
    fetch_valid_i = 1'b0;
  endtask

  task automatic lsu_access(input mem_pkg::mem_op_e op, input mem_pkg::addr_t addr,
                            input mem_pkg::word_t wdata, output mem_pkg::word_t rdata,
                            output logic err, output int waits, output int order);
    lsu_valid_i = 1'b1;
    lsu_op_i    = op;
    lsu_addr_i  = addr;
    lsu_wdata_i = wdata;
    @(negedge clk);
    waits = 1;
    while (!lsu_done_o) begin
      @(negedge clk);
      waits++;
    end
    rdata = lsu_rdata_o;
    err   = lsu_err_o;
    order = done_seq;
    done_seq++;
    @(posedge clk);
    #5;
    lsu_valid_i = 1'b0;
  endtask

  task automatic store_check(input mem_pkg::mem_op_e op, input mem_pkg::addr_t addr,
                             input mem_pkg::word_t data);
    mem_pkg::word_t rd;
    mem_pkg::word_t lanes;
    mem_pkg::word_t mask;
    mem_pkg::strb_t strb;
    logic           err;
    int             waits;
    int             ord;
    lsu_access(op, addr, data, rd, err, waits, ord);
    strb = exp_strb(op, addr[1:0]);
    for (int b = 0; b < 4; b++) mask[8*b +: 8] = {8{strb[b]}};
    case (op)
      mem_pkg::SB: lanes = {4{data[7:0]}};
      mem_pkg::SH: lanes = {2{data[15:0]}};
      default:     lanes = data;
    endcase
    check_eq("lsu_err_o", err, 1'b0);
    verify_addr_beat("aw", mem_pkg::axi_ar_t'(last_aw), DATA_ID, addr);
    check_eq("wstrb", last_w.strb, strb);
    check_eq("wdata", last_w.data & mask, lanes & mask);
    check_eq("wlast", last_w.last, 1'b1);
  endtask

  task automatic load_check(input mem_pkg::mem_op_e op, input mem_pkg::addr_t addr,
                            input mem_pkg::word_t exp);
    mem_pkg::word_t rd;
    logic           err;
    int             waits;
    int             ord;
    lsu_access(op, addr, 32'h0, rd, err, waits, ord);
    check_eq("lsu_rdata_o", rd, exp);
    check_eq("lsu_err_o", err, 1'b0);
    verify_addr_beat("ar", last_ar, DATA_ID, addr);
  endtask

  // bus monitor sampled mid-cycle where nothing moves
  always @(negedge clk) begin
    if (!arst_n_i) begin
      check_eq("ar_valid_o", ar_valid_o, 1'b0);
      check_eq("aw_valid_o", aw_valid_o, 1'b0);
      check_eq("w_valid_o", w_valid_o, 1'b0);
      check_eq("r_ready_o", r_ready_o, 1'b0);
      check_eq("b_ready_o", b_ready_o, 1'b0);
      check_eq("fetch_done_o", fetch_done_o, 1'b0);
      check_eq("lsu_done_o", lsu_done_o, 1'b0);
    end else begin
      if (ar_valid_o | aw_valid_o | w_valid_o) valid_cycles++;
      if (ar_wait) begin
        check_eq("ar_valid_o", ar_valid_o, 1'b1);  // no retraction before ready
        check_eq("ar_o", ar_o, ar_prev);
      end
      if (aw_wait) begin
        check_eq("aw_valid_o", aw_valid_o, 1'b1);
        check_eq("aw_o", aw_o, aw_prev);
      end
      if (w_wait) begin
        check_eq("w_valid_o", w_valid_o, 1'b1);
        check_eq("w_o", w_o, w_prev);
      end
      require(!(fetch_done_o && fetch_done_q), "fetch_done_o stayed high for two cycles");
      require(!(lsu_done_o && lsu_done_q), "lsu_done_o stayed high for two cycles");
      if (ar_valid_o && ar_ready_i) last_ar = ar_o;
      if (aw_valid_o && aw_ready_i) last_aw = aw_o;
      if (w_valid_o && w_ready_i) last_w = w_o;
    end
    ar_wait      = ar_valid_o & ~ar_ready_i;
    aw_wait      = aw_valid_o & ~aw_ready_i;
    w_wait       = w_valid_o & ~w_ready_i;
    ar_prev      = ar_o;
    aw_prev      = aw_o;
    w_prev       = w_o;
    fetch_done_q = fetch_done_o;
    lsu_done_q   = lsu_done_o;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("watchdog: run stopped after %0d cycles, a request never completed",
             TIMEOUT_CYCLES);
    errors++;
    $display("errors: %0d", errors);
    $display("Checks failed");
    $finish;
  end

  initial begin
    mem_pkg::mem_rsp_t frsp;
    mem_pkg::word_t    rd;
    mem_pkg::addr_t    fa;
    logic              err;
    int                waits;
    int                ord_f;
    int                ord_d;
    int                vcount;
    arst_n_i      = 1'b0;
    fetch_valid_i = 1'b0;
    fetch_addr_i  = '0;
    lsu_valid_i   = 1'b0;
    lsu_op_i      = mem_pkg::LW;
    lsu_addr_i    = '0;
    lsu_wdata_i   = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #5;
    arst_n_i = 1'b1;

    // fetches with the low address bits dropped by the arbiter
    for (int i = 0; i < 8; i++) begin
      fa = 32'h40 + 32'(i * 20) + 32'(i % 4);
      fetch(fa, frsp, ord_f);
      check_eq("fetch_rsp_o.rdata", frsp.rdata, model_word(fa));
      check_eq("fetch_rsp_o.err", frsp.err, 1'b0);
      verify_addr_beat("ar", last_ar, FETCH_ID, fa);
    end

    // stores then loads over the same word
    store_check(mem_pkg::SW, 32'h100, 32'h8bad_f00d);
    load_check(mem_pkg::LW, 32'h100, 32'h8bad_f00d);
    store_check(mem_pkg::SB, 32'h101, 32'h0000_00c7);
    load_check(mem_pkg::LBU, 32'h101, 32'h0000_00c7);
    load_check(mem_pkg::LB, 32'h101, 32'hffff_ffc7);
    store_check(mem_pkg::SH, 32'h102, 32'h1234_8012);  // upper half not stored
    load_check(mem_pkg::LH, 32'h102, 32'hffff_8012);
    load_check(mem_pkg::LHU, 32'h102, 32'h0000_8012);
    load_check(mem_pkg::LW, 32'h100, 32'h8012_c70d);

    // sub-word loads of the fill pattern
    for (int k = 0; k < 4; k++) begin
      fa = 32'h200 + 32'(k);
      load_check(mem_pkg::LB, fa, exp_load(mem_pkg::LB, model_word(fa), fa[1:0]));
      fa = 32'h210 + 32'(k);
      load_check(mem_pkg::LBU, fa, exp_load(mem_pkg::LBU, model_word(fa), fa[1:0]));
    end
    for (int k = 0; k < 2; k++) begin
      fa = 32'h220 + 32'(2 * k);
      load_check(mem_pkg::LH, fa, exp_load(mem_pkg::LH, model_word(fa), fa[1:0]));
      fa = 32'h230 + 32'(2 * k);
      load_check(mem_pkg::LHU, fa, exp_load(mem_pkg::LHU, model_word(fa), fa[1:0]));
    end

    // both ports raised together so the data port wins
    fork
      fetch(32'h300, frsp, ord_f);
      lsu_access(mem_pkg::LW, 32'h100, 32'h0, rd, err, waits, ord_d);
    join
    require(ord_d < ord_f, "data request did not finish before the fetch raised with it");
    check_eq("lsu_rdata_o", rd, 32'h8012_c70d);
    check_eq("fetch_rsp_o.rdata", frsp.rdata, model_word(32'h300));
    verify_addr_beat("ar", last_ar, FETCH_ID, 32'h300);

    // misaligned accesses stay off the bus
    vcount = valid_cycles;
    lsu_access(mem_pkg::LW, 32'h102, 32'h0, rd, err, waits, ord_d);
    check_eq("lsu_err_o", err, 1'b1);
    check_eq("lsu_rdata_o", rd, 32'h0);
    require(waits == 2, "misaligned LW was not answered one cycle after it was sampled");
    lsu_access(mem_pkg::SH, 32'h101, 32'h5555, rd, err, waits, ord_d);
    check_eq("lsu_err_o", err, 1'b1);
    require(waits == 2, "misaligned SH was not answered one cycle after it was sampled");
    require(valid_cycles == vcount, "a misaligned access raised an AXI valid");

    // slave error on the error address
    lsu_access(mem_pkg::LW, ERR_ADDR, 32'h0, rd, err, waits, ord_d);
    check_eq("lsu_err_o", err, 1'b1);
    lsu_access(mem_pkg::SW, ERR_ADDR, 32'hdead_beef, rd, err, waits, ord_d);
    check_eq("lsu_err_o", err, 1'b1);
    fetch(ERR_ADDR, frsp, ord_f);
    check_eq("fetch_rsp_o.err", frsp.err, 1'b1);

    @(posedge clk);
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
design/mem_pkg.sv
design/lsu_align.sv
design/bus_arbiter.sv
design/axi4_master.sv
design/mem_subsys_top.sv
tests/axi_mem_model.sv
tests/tb_top.sv
